//--- source/riscv_isa_pkg.sv
// instruction set encodings for the RV64 integer divide path
// opcode, funct fields and machine width codes used by the decoder

package riscv_isa_pkg;

  ///////////////////////////////
  // widths
  ///////////////////////////////

  // register width of the core
  localparam int xlen = 64;

  // operand and result values
  typedef logic [xlen-1:0] xlen_t;

  // one instruction word
  typedef logic [31:0] instr_t;

  // machine width as reported by the state unit
  typedef logic [1:0] xlen_mode_t;

  // misa style width codes
  localparam xlen_mode_t rv32i = 2'b01;
  localparam xlen_mode_t rv64i = 2'b10;

  ///////////////////////////////
  // opcodes
  ///////////////////////////////

  // register-register ops, full width
  localparam logic [6:0] op_op   = 7'b0110011;
  // register-register ops, word forms
  localparam logic [6:0] op_op32 = 7'b0111011;

  ///////////////////////////////
  // funct fields
  ///////////////////////////////

  // shared by every M extension instruction
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // divide group of the M extension
  localparam logic [2:0] f3_div  = 3'b100;
  localparam logic [2:0] f3_divu = 3'b101;
  localparam logic [2:0] f3_rem  = 3'b110;
  localparam logic [2:0] f3_remu = 3'b111;

endpackage

//--- source/div_unit_pkg.sv
// types private to the divide unit
// request and result bundles between decode, execute and result stages

package div_unit_pkg;

  ///////////////////////////////
  // widths
  ///////////////////////////////

  // operand width of the word forms
  localparam int word_bits = 32;

  // iteration counter, counts down from 63 or 31
  typedef logic [5:0] cnt_t;

  ///////////////////////////////
  // bundles
  ///////////////////////////////

  // what the instruction asks for
  typedef struct packed {
    logic is_rem;
    logic is_signed;
    logic is_word;
  } div_op_t;

  // prepared request, operands already made positive
  typedef struct packed {
    div_op_t              op;
    logic                 neg_q;
    logic                 neg_r;
    riscv_isa_pkg::xlen_t dividend;
    riscv_isa_pkg::xlen_t divisor;
    logic                 early;
    riscv_isa_pkg::xlen_t early_value;
  } div_req_t;

  // finished divider state, still unsigned
  typedef struct packed {
    div_op_t              op;
    logic                 neg_q;
    logic                 neg_r;
    riscv_isa_pkg::xlen_t quotient;
    riscv_isa_pkg::xlen_t remainder;
    logic                 early;
    riscv_isa_pkg::xlen_t early_value;
  } div_raw_t;

  // execute FSM
  typedef enum logic [1:0] {
    idle,
    iterate,
    finish
  } div_state_e;

  // sign extend a word value to register width
  function automatic riscv_isa_pkg::xlen_t sext_word(input logic [word_bits-1:0] value);
    sext_word = {{(riscv_isa_pkg::xlen - word_bits){value[word_bits-1]}}, value};
  endfunction

endpackage

//--- source/div_decode.sv
// divide instruction decoder, purely combinational
// turns the instruction and raw operands into a prepared divider request

`timescale 1ns/1ns

module div_decode (
  input  riscv_isa_pkg::instr_t     id_instr,
  input  riscv_isa_pkg::xlen_t      opa,
  input  riscv_isa_pkg::xlen_t      opb,
  input  riscv_isa_pkg::xlen_mode_t st_xlen,
  input  logic                      id_bubble,
  output div_unit_pkg::div_req_t    req,
  output logic                      req_valid
);

  // instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // classification
  logic is_muldiv;
  logic is_div_f3;
  logic word_ok;
  div_unit_pkg::div_op_t op;

  // operands after width selection
  riscv_isa_pkg::xlen_t a_val;
  riscv_isa_pkg::xlen_t b_val;
  riscv_isa_pkg::xlen_t abs_a;
  riscv_isa_pkg::xlen_t abs_b;
  logic                 a_neg;
  logic                 b_neg;

  // early result cases
  riscv_isa_pkg::xlen_t min_neg;
  riscv_isa_pkg::xlen_t rem_zero_value;
  logic                 div_zero;
  logic                 overflow;

  assign opcode = id_instr[6:0];
  assign funct3 = id_instr[14:12];
  assign funct7 = id_instr[31:25];

  assign is_muldiv = (funct7 == riscv_isa_pkg::funct7_muldiv);
  // word forms only exist on a 64 bit machine
  assign word_ok   = (st_xlen != riscv_isa_pkg::rv32i);

  ///////////////////////////////
  // operation select
  ///////////////////////////////

  always_comb begin
    is_div_f3    = 1'b1;
    op.is_rem    = 1'b0;
    op.is_signed = 1'b0;
    op.is_word   = (opcode == riscv_isa_pkg::op_op32);
    case (funct3)
      riscv_isa_pkg::f3_div: op.is_signed = 1'b1;
      riscv_isa_pkg::f3_divu: is_div_f3 = 1'b1;
      riscv_isa_pkg::f3_rem: begin
        op.is_rem    = 1'b1;
        op.is_signed = 1'b1;
      end
      riscv_isa_pkg::f3_remu: op.is_rem = 1'b1;
      default: is_div_f3 = 1'b0;
    endcase
  end

  // recognized divide, not in a bubble
  assign req_valid = !id_bubble && is_muldiv && is_div_f3 &&
                     ((opcode == riscv_isa_pkg::op_op) ||
                      ((opcode == riscv_isa_pkg::op_op32) && word_ok));

  ///////////////////////////////
  // operands
  ///////////////////////////////

  always_comb begin
    // word forms look at the low half only
    if (op.is_word && op.is_signed) begin
      a_val = div_unit_pkg::sext_word(opa[div_unit_pkg::word_bits-1:0]);
      b_val = div_unit_pkg::sext_word(opb[div_unit_pkg::word_bits-1:0]);
    end else if (op.is_word) begin
      a_val = riscv_isa_pkg::xlen_t'(opa[div_unit_pkg::word_bits-1:0]);
      b_val = riscv_isa_pkg::xlen_t'(opb[div_unit_pkg::word_bits-1:0]);
    end else begin
      a_val = opa;
      b_val = opb;
    end
    a_neg = op.is_signed && a_val[riscv_isa_pkg::xlen-1];
    b_neg = op.is_signed && b_val[riscv_isa_pkg::xlen-1];
    abs_a = a_neg ? -a_val : a_val;
    abs_b = b_neg ? -b_val : b_val;
  end

  // most negative value of the selected width
  assign min_neg = op.is_word ? div_unit_pkg::sext_word({1'b1, 31'b0}) :
                                {1'b1, {(riscv_isa_pkg::xlen-1){1'b0}}};

  // remainder by zero returns the dividend, word forms always sign extended
  assign rem_zero_value = op.is_word ? div_unit_pkg::sext_word(opa[div_unit_pkg::word_bits-1:0])
                                     : opa;

  assign div_zero = (b_val == '0);
  assign overflow = op.is_signed && (a_val == min_neg) && (&b_val);

  ///////////////////////////////
  // request
  ///////////////////////////////

  always_comb begin
    req.op      = op;
    req.neg_q   = a_neg ^ b_neg;
    // remainder follows the dividend sign
    req.neg_r   = a_neg;
    // word dividend sits in the upper half so 32 steps suffice
    req.dividend = op.is_word ? {abs_a[div_unit_pkg::word_bits-1:0],
                                 {div_unit_pkg::word_bits{1'b0}}} : abs_a;
    req.divisor = abs_b;
    req.early   = div_zero || overflow;
    if (div_zero) begin
      req.early_value = op.is_rem ? rem_zero_value : '1;
    end else begin
      req.early_value = op.is_rem ? '0 : min_neg;
    end
  end

endmodule

//--- source/div_execute.sv
// bit serial restoring divider, one quotient bit per cycle
// holds one request at a time and hands the unsigned result to the result stage

`timescale 1ns/1ns

module div_execute (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   ex_stall,
  input  div_unit_pkg::div_req_t req,
  input  logic                   req_valid,
  output div_unit_pkg::div_raw_t raw,
  output logic                   raw_valid,
  output logic                   div_stall
);

  // FSM and loop count
  div_unit_pkg::div_state_e state;
  div_unit_pkg::cnt_t       cnt;

  // request held for the whole division
  div_unit_pkg::div_req_t req_q;

  // partial remainder and dividend/quotient pair
  riscv_isa_pkg::xlen_t pa_p;
  riscv_isa_pkg::xlen_t pa_a;

  // one extra bit so large unsigned divisors do not overflow
  logic [riscv_isa_pkg::xlen:0]   trial;
  logic [riscv_isa_pkg::xlen+1:0] diff;
  logic                           borrow;

  // step qualifiers
  logic accept;
  logic load;
  logic step;

  assign accept = (state == div_unit_pkg::idle) && req_valid && !ex_stall;
  // first iterate cycle loads the datapath, stall not yet up
  assign load   = (state == div_unit_pkg::iterate) && !div_stall;
  assign step   = (state == div_unit_pkg::iterate) && div_stall;

  ///////////////////////////////
  // restoring step
  ///////////////////////////////

  // shift pair left by one, top dividend bit enters the remainder
  assign trial  = {pa_p, pa_a[riscv_isa_pkg::xlen-1]};
  assign diff   = {1'b0, trial} - {2'b00, req_q.divisor};
  assign borrow = diff[riscv_isa_pkg::xlen+1];

  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= req;
    end
    if (load) begin
      pa_p <= '0;
      pa_a <= req_q.dividend;
    end else if (step) begin
      // borrow means restore, quotient bit 0
      pa_p <= borrow ? trial[riscv_isa_pkg::xlen-1:0] : diff[riscv_isa_pkg::xlen-1:0];
      pa_a <= {pa_a[riscv_isa_pkg::xlen-2:0], ~borrow};
    end
  end

  ///////////////////////////////
  // control FSM
  ///////////////////////////////

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state     <= div_unit_pkg::idle;
      cnt       <= '0;
      raw_valid <= 1'b0;
      div_stall <= 1'b0;
    end else begin
      raw_valid <= 1'b0;
      case (state)
        div_unit_pkg::idle: begin
          if (accept) begin
            // 64 steps for full width, 32 for word forms
            cnt   <= req.op.is_word ? div_unit_pkg::cnt_t'(div_unit_pkg::word_bits - 1)
                                    : div_unit_pkg::cnt_t'(riscv_isa_pkg::xlen - 1);
            // early results skip the loop
            state <= req.early ? div_unit_pkg::finish : div_unit_pkg::iterate;
          end
        end
        div_unit_pkg::iterate: begin
          if (!div_stall) begin
            div_stall <= 1'b1;
          end else begin
            cnt <= cnt - 1'b1;
            if (cnt == '0) begin
              state <= div_unit_pkg::finish;
            end
          end
        end
        div_unit_pkg::finish: begin
          // result handed over, release the pipeline
          raw_valid <= 1'b1;
          div_stall <= 1'b0;
          state     <= div_unit_pkg::idle;
        end
        default: state <= div_unit_pkg::idle;
      endcase
    end
  end

  // finished state, read by the result stage on raw_valid
  always_comb begin
    raw.op          = req_q.op;
    raw.neg_q       = req_q.neg_q;
    raw.neg_r       = req_q.neg_r;
    raw.quotient    = pa_a;
    raw.remainder   = pa_p;
    raw.early       = req_q.early;
    raw.early_value = req_q.early_value;
  end

endmodule

//--- source/div_result.sv
// result stage of the divide unit
// fixes signs, picks quotient or remainder and registers the write back value

`timescale 1ns/1ns

module div_result (
  input  logic                   clk,
  input  logic                   rstn,
  input  div_unit_pkg::div_raw_t raw,
  input  logic                   raw_valid,
  output logic                   div_bubble,
  output riscv_isa_pkg::xlen_t   div_r
);

  // unsigned value before sign fix-up
  riscv_isa_pkg::xlen_t magnitude;
  logic                 negate;
  riscv_isa_pkg::xlen_t signed_value;
  riscv_isa_pkg::xlen_t result;

  ///////////////////////////////
  // sign fix-up
  ///////////////////////////////

  always_comb begin
    if (raw.op.is_rem) begin
      magnitude = raw.remainder;
      negate    = raw.neg_r;
    end else begin
      magnitude = raw.quotient;
      negate    = raw.neg_q;
    end
    signed_value = negate ? -magnitude : magnitude;

    // early values are already final
    result = raw.early ? raw.early_value : signed_value;

    // word forms return bit 31 extended
    if (raw.op.is_word) begin
      result = div_unit_pkg::sext_word(result[div_unit_pkg::word_bits-1:0]);
    end
  end

  ///////////////////////////////
  // output registers
  ///////////////////////////////

  always_ff @(posedge clk) begin
    if (raw_valid) begin
      div_r <= result;
    end
  end

  // one valid cycle per finished division
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      div_bubble <= 1'b1;
    end else begin
      div_bubble <= !raw_valid;
    end
  end

endmodule

//--- source/div_unit.sv
// RV64M integer divide unit for the execute stage
// decode, serial divider and result stage behind the pipeline handshake

`timescale 1ns/1ns

module div_unit (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      ex_stall,
  input  logic                      id_bubble,
  input  riscv_isa_pkg::instr_t     id_instr,
  input  riscv_isa_pkg::xlen_t      opa,
  input  riscv_isa_pkg::xlen_t      opb,
  input  riscv_isa_pkg::xlen_mode_t st_xlen,
  output logic                      div_stall,
  output logic                      div_bubble,
  output riscv_isa_pkg::xlen_t      div_r
);

  // decode to execute
  div_unit_pkg::div_req_t req;
  logic                   req_valid;

  // execute to result
  div_unit_pkg::div_raw_t raw;
  logic                   raw_valid;

  div_decode u_decode (
    .id_instr  (id_instr),
    .opa       (opa),
    .opb       (opb),
    .st_xlen   (st_xlen),
    .id_bubble (id_bubble),
    .req       (req),
    .req_valid (req_valid)
  );

  div_execute u_execute (
    .clk       (clk),
    .rstn      (rstn),
    .ex_stall  (ex_stall),
    .req       (req),
    .req_valid (req_valid),
    .raw       (raw),
    .raw_valid (raw_valid),
    .div_stall (div_stall)
  );

  div_result u_result (
    .clk        (clk),
    .rstn       (rstn),
    .raw        (raw),
    .raw_valid  (raw_valid),
    .div_bubble (div_bubble),
    .div_r      (div_r)
  );

endmodule

//--- bench/div_unit_tb.sv
// self-checking testbench for the RV64M divide unit
// directed table plus random vectors checked against a behavioral model

`timescale 1ns/1ns

module div_unit_tb;

  // one table entry per instruction
  // f3 is 100 for div and 101 for divu
  // 110 for rem and 111 for remu
  typedef struct packed {
    logic                      word;
    logic [2:0]                f3;
    riscv_isa_pkg::xlen_mode_t mode;
    logic [3:0]                hold;
    riscv_isa_pkg::xlen_t      a;
    riscv_isa_pkg::xlen_t      b;
    riscv_isa_pkg::xlen_t      expected;
  } vec_t;

  logic                      clk;
  logic                      rstn;
  logic                      ex_stall;
  logic                      id_bubble;
  riscv_isa_pkg::instr_t     id_instr;
  riscv_isa_pkg::xlen_t      opa;
  riscv_isa_pkg::xlen_t      opb;
  riscv_isa_pkg::xlen_mode_t st_xlen;
  logic                      div_stall;
  logic                      div_bubble;
  riscv_isa_pkg::xlen_t      div_r;

  // all vectors with the directed ones first
  vec_t vecs[$];

  div_unit DUT (
    .clk        (clk),
    .rstn       (rstn),
    .ex_stall   (ex_stall),
    .id_bubble  (id_bubble),
    .id_instr   (id_instr),
    .opa        (opa),
    .opb        (opb),
    .st_xlen    (st_xlen),
    .div_stall  (div_stall),
    .div_bubble (div_bubble),
    .div_r      (div_r)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // sources x1 and x2 into destination x3
  function automatic riscv_isa_pkg::instr_t make_instr(input logic word, input logic [2:0] f3);
    make_instr = {riscv_isa_pkg::funct7_muldiv, 5'd2, 5'd1, f3, 5'd3,
                  word ? riscv_isa_pkg::op_op32 : riscv_isa_pkg::op_op};
  endfunction

  // quotient truncates toward zero and the remainder follows the dividend
  function automatic riscv_isa_pkg::xlen_t ref_result(input logic word, input logic [2:0] f3,
      input riscv_isa_pkg::xlen_t a, input riscv_isa_pkg::xlen_t b);
    logic                 is_rem;
    logic                 is_signed;
    logic [31:0]          wa;
    logic [31:0]          wb;
    logic [31:0]          w;
    riscv_isa_pkg::xlen_t r;
    is_rem    = f3[1];
    is_signed = !f3[0];
    wa        = a[31:0];
    wb        = b[31:0];
    if (word) begin
      if (wb == 32'd0) begin
        w = is_rem ? wa : '1;
      end else if (is_signed && wa == 32'h8000_0000 && wb == '1) begin
        w = is_rem ? 32'd0 : wa;
      end else if (is_signed) begin
        w = is_rem ? $signed(wa) % $signed(wb) : $signed(wa) / $signed(wb);
      end else begin
        w = is_rem ? wa % wb : wa / wb;
      end
      // word results always come back sign extended
      r = {{32{w[31]}}, w};
    end else begin
      if (b == 64'd0) begin
        r = is_rem ? a : '1;
      end else if (is_signed && a == {1'b1, 63'd0} && b == '1) begin
        r = is_rem ? 64'd0 : a;
      end else if (is_signed) begin
        r = is_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
      end else begin
        r = is_rem ? a % b : a / b;
      end
    end
    ref_result = r;
  endfunction

  // divide by zero or signed overflow skips the iterations
  function automatic logic is_early(input logic word, input logic [2:0] f3,
      input riscv_isa_pkg::xlen_t a, input riscv_isa_pkg::xlen_t b);
    logic zero;
    logic ovf;
    if (word) begin
      zero = (b[31:0] == 32'd0);
      ovf  = (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
    end else begin
      zero = (b == 64'd0);
      ovf  = (a == {1'b1, 63'd0}) && (b == '1);
    end
    is_early = zero || (ovf && !f3[0]);
  endfunction

  //////////////////////////////
  // vector table
  //////////////////////////////

  task automatic add_vec(input logic word, input logic [2:0] f3, input logic rv32,
      input logic [3:0] hold, input riscv_isa_pkg::xlen_t a, input riscv_isa_pkg::xlen_t b,
      input riscv_isa_pkg::xlen_t expected);
    vec_t v;
    v.word     = word;
    v.f3       = f3;
    v.mode     = rv32 ? riscv_isa_pkg::rv32i : riscv_isa_pkg::rv64i;
    v.hold     = hold;
    v.a        = a;
    v.b        = b;
    v.expected = expected;
    vecs.push_back(v);
  endtask

  task automatic load_table();
    riscv_isa_pkg::xlen_t min64;
    riscv_isa_pkg::xlen_t ga;
    riscv_isa_pkg::xlen_t gb;
    min64 = {1'b1, 63'd0};
    // every sign combination at full width
    add_vec(1'b0, 3'b100, 1'b0, 4'd0, 64'd100, 64'd7, 64'd14);
    add_vec(1'b0, 3'b100, 1'b0, 4'd0, -64'd100, 64'd7, -64'd14);
    add_vec(1'b0, 3'b110, 1'b0, 4'd0, -64'd100, 64'd7, -64'd2);
    add_vec(1'b0, 3'b100, 1'b0, 4'd0, 64'd100, -64'd7, -64'd14);
    add_vec(1'b0, 3'b110, 1'b0, 4'd0, 64'd100, -64'd7, 64'd2);
    add_vec(1'b0, 3'b100, 1'b0, 4'd0, -64'd100, -64'd7, 64'd14);
    add_vec(1'b0, 3'b110, 1'b0, 4'd0, -64'd100, -64'd7, -64'd2);
    // unsigned with large operands and divisor
    add_vec(1'b0, 3'b101, 1'b0, 4'd0, -64'd1, 64'd2, 64'h7FFF_FFFF_FFFF_FFFF);
    add_vec(1'b0, 3'b111, 1'b0, 4'd0, -64'd1, 64'd2, 64'd1);
    add_vec(1'b0, 3'b101, 1'b0, 4'd0, min64, -64'd1, 64'd0);
    add_vec(1'b0, 3'b111, 1'b0, 4'd0, min64, -64'd1, min64);
    // divide by zero
    add_vec(1'b0, 3'b100, 1'b0, 4'd0, 64'd5, 64'd0, -64'd1);
    add_vec(1'b0, 3'b101, 1'b0, 4'd0, 64'd5, 64'd0, -64'd1);
    add_vec(1'b0, 3'b110, 1'b0, 4'd0, -64'd5, 64'd0, -64'd5);
    add_vec(1'b0, 3'b111, 1'b0, 4'd0, 64'd123, 64'd0, 64'd123);
    // signed overflow at full and word width
    add_vec(1'b0, 3'b100, 1'b0, 4'd0, min64, -64'd1, min64);
    add_vec(1'b0, 3'b110, 1'b0, 4'd0, min64, -64'd1, 64'd0);
    ga = 64'h1234_5678_8000_0000;
    gb = 64'hABCD_0000_FFFF_FFFF;
    add_vec(1'b1, 3'b100, 1'b0, 4'd0, ga, gb, 64'hFFFF_FFFF_8000_0000);
    add_vec(1'b1, 3'b110, 1'b0, 4'd0, ga, gb, 64'd0);
    // word forms with garbage in the upper halves
    ga = 64'hDEAD_BEEF_FFFF_FF9C;
    gb = 64'h1111_1111_0000_0007;
    add_vec(1'b1, 3'b100, 1'b0, 4'd0, ga, gb, -64'd14);
    add_vec(1'b1, 3'b110, 1'b0, 4'd0, ga, gb, -64'd2);
    add_vec(1'b1, 3'b101, 1'b0, 4'd0, 64'h0000_0001_FFFF_FFFE, 64'h0000_0001_0000_0001,
            -64'd2);
    add_vec(1'b1, 3'b111, 1'b0, 4'd0, 64'hAAAA_AAAA_0000_0064, 64'h5555_5555_0000_0007,
            64'd2);
    add_vec(1'b1, 3'b101, 1'b0, 4'd0, 64'h7777_0000_8000_0000, 64'h9999_0000_0000_0001,
            64'hFFFF_FFFF_8000_0000);
    add_vec(1'b1, 3'b101, 1'b0, 4'd0, 64'd9, 64'hFFFF_FFFF_0000_0000, -64'd1);
    add_vec(1'b1, 3'b110, 1'b0, 4'd0, 64'h0000_0000_8000_0001, 64'h1_0000_0000,
            64'hFFFF_FFFF_8000_0001);
    // rv32i ignores the word form and still runs a plain DIV
    add_vec(1'b1, 3'b100, 1'b1, 4'd0, 64'd100, 64'd7, 64'd0);
    add_vec(1'b0, 3'b100, 1'b1, 4'd0, 64'd100, 64'd7, 64'd14);
    // held off by ex_stall first
    add_vec(1'b0, 3'b100, 1'b0, 4'd6, 64'd1000, -64'd3, -64'd333);
    add_vec(1'b1, 3'b111, 1'b0, 4'd4, 64'd1000, 64'd7, 64'd6);
  endtask

  // random operands with a varied divisor width for useful quotients
  task automatic add_random(input int count);
    logic                 word;
    logic [2:0]           f3;
    riscv_isa_pkg::xlen_t a;
    riscv_isa_pkg::xlen_t b;
    int                   sh;
    repeat (count) begin
      word = 1'($urandom_range(0, 1));
      f3   = 3'b100 | 3'($urandom_range(0, 3));
      a    = {$urandom, $urandom};
      sh   = $urandom_range(0, 62);
      b    = {$urandom, $urandom} >> sh;
      if ($urandom_range(0, 1) == 1) begin
        b = -b;
      end
      add_vec(word, f3, 1'b0, 4'd0, a, b, ref_result(word, f3, a, b));
    end
  endtask

  //////////////////////////////
  // driving and checking
  //////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopping at the first failed check");
  endtask

  task automatic apply_vec(input int idx, input vec_t v);
    logic expect_out;
    logic early;
    logic seen_stall;
    int   cycles;
    int   latency;
    expect_out = !(v.word && v.mode == riscv_isa_pkg::rv32i);
    early      = is_early(v.word, v.f3, v.a, v.b);
    seen_stall = 1'b0;
    // cycles from the accepting edge until div_bubble drops
    latency    = early ? 2 : (v.word ? 35 : 67);
    @(negedge clk);
    id_instr  = make_instr(v.word, v.f3);
    opa       = v.a;
    opb       = v.b;
    st_xlen   = v.mode;
    id_bubble = 1'b0;
    ex_stall  = (v.hold != 4'd0);
    // nothing may start while the next stage stalls
    cycles = 0;
    while (cycles < int'(v.hold)) begin
      @(negedge clk);
      assert (div_bubble && !div_stall)
        else fail_run($sformatf("error at %0t: vector %0d started while ex_stall was high",
                                $time, idx));
      cycles++;
    end
    ex_stall = 1'b0;
    @(negedge clk);
    id_bubble = 1'b1;
    if (expect_out) begin
      cycles = 0;
      while (div_bubble && cycles < 100) begin
        if (div_stall) begin
          seen_stall = 1'b1;
        end
        @(negedge clk);
        cycles++;
      end
      assert (!div_bubble)
        else fail_run($sformatf("no result arrived within 100 cycles for vector %0d", idx));
      assert (cycles == latency)
        else fail_run($sformatf("error at %0t: vector %0d took %0d cycles, expected %0d",
                                $time, idx, cycles, latency));
      assert (div_r == v.expected)
        else fail_run($sformatf("error at %0t: vector %0d gave %h, expected %h",
                                $time, idx, div_r, v.expected));
      // stall only for real iterations and released at the result
      assert (seen_stall == !early && !div_stall)
        else fail_run($sformatf("error at %0t: div_stall wrong around vector %0d",
                                $time, idx));
      @(negedge clk);
      assert (div_bubble)
        else fail_run($sformatf("error at %0t: result of vector %0d valid for more than one cycle",
                                $time, idx));
    end else begin
      repeat (100) begin
        @(negedge clk);
        assert (div_bubble && !div_stall)
          else fail_run($sformatf("error at %0t: vector %0d gave a result in rv32i mode",
                                  $time, idx));
      end
    end
  endtask

  initial begin
    void'($urandom(32'h24655fda));
    rstn      = 1'b0;
    ex_stall  = 1'b0;
    id_bubble = 1'b1;
    id_instr  = '0;
    opa       = '0;
    opb       = '0;
    st_xlen   = riscv_isa_pkg::rv64i;
    load_table();
    add_random(40);
    repeat (10) @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    assert (div_bubble && !div_stall)
      else fail_run($sformatf("error at %0t: outputs not idle after reset", $time));
    foreach (vecs[i]) begin
      apply_vec(i, vecs[i]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

//--- div_unit.f
source/riscv_isa_pkg.sv
source/div_unit_pkg.sv
source/div_decode.sv
source/div_execute.sv
source/div_result.sv
source/div_unit.sv
bench/div_unit_tb.sv

//--- Makefile
# Verilator build and run for the RV64M divide unit testbench

VERILATOR ?= verilator
TOP       ?= div_unit_tb
FILELIST  ?= div_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
